// File: Bender.yml
package:
  name: cart_loader

sources:
  - include_dirs:
      - common
    files:
      - common/cart_pkg.sv
      - logic/rom_write_ctrl.sv
      - logic/cheat_code_loader.sv
      - cart_loader/header_region.sv
      - cart_loader/region_select.sv
      - cart_loader/quirk_lookup.sv
      - cart_loader/cart_loader_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - test/cart_loader_checker.sv
      - test/cart_loader_tb.sv

// File: cart_loader/cart_loader_top.sv
//////////////////////////////////////////////////
// Cartridge loader top, joins ROM write, header,
// region, quirk and cheat blocks
//////////////////////////////////////////////////
`timescale 1ns/100ps

module cart_loader_top
	import cart_pkg::*;
(
	input  logic         clk_sys,
	input  logic         RESET,
	input  ioctl_t       ioctl,
	input  region_mode_t region_mode,
	input  region_prio_t region_prio,
	input  logic         rom_wr_ack,
	output logic         rom_wr,
	output rom_addr_t    rom_addr,
	output rom_word_t    rom_data,
	output logic         ioctl_wait,
	output rom_addr_t    rom_size,
	output region_t      region_req,
	output logic         region_set,
	output quirk_t       quirks,
	output gun_cfg_t     gun_cfg,
	output cheat_code_t  cheat
);
	hdr_flags_t hdr_flags;
	logic       hdr_ready;

	rom_write_ctrl rom_write_ctrl0 (
		.clk_sys    (clk_sys),
		.RESET      (RESET),
		.ioctl      (ioctl),
		.rom_wr_ack (rom_wr_ack),
		.rom_wr     (rom_wr),
		.rom_addr   (rom_addr),
		.rom_data   (rom_data),
		.ioctl_wait (ioctl_wait),
		.rom_size   (rom_size)
	);

	//////////////////////////////////////////////////
	// Header parse and region choice
	header_region header_region0 (
		.clk_sys   (clk_sys),
		.RESET     (RESET),
		.ioctl     (ioctl),
		.hdr_flags (hdr_flags),
		.hdr_ready (hdr_ready)
	);

	region_select region_select0 (
		.clk_sys     (clk_sys),
		.RESET       (RESET),
		.hdr_flags   (hdr_flags),
		.hdr_ready   (hdr_ready),
		.ioctl       (ioctl),
		.region_mode (region_mode),
		.region_prio (region_prio),
		.region_req  (region_req),
		.region_set  (region_set)
	);

	quirk_lookup quirk_lookup0 (
		.clk_sys (clk_sys),
		.RESET   (RESET),
		.ioctl   (ioctl),
		.quirks  (quirks),
		.gun_cfg (gun_cfg)
	);

	cheat_code_loader cheat_code_loader0 (
		.clk_sys (clk_sys),
		.RESET   (RESET),
		.ioctl   (ioctl),
		.cheat   (cheat)
	);

endmodule

// File: cart_loader/header_region.sv
//////////////////////////////////////////////////
// Header region decode, letters or hex digit
//////////////////////////////////////////////////
`timescale 1ns/100ps
`include "cart_macros.svh"

module header_region
	import cart_pkg::*;
(
	input  logic       clk_sys,
	input  logic       RESET,
	input  ioctl_t     ioctl,
	output hdr_flags_t hdr_flags,
	output logic       hdr_ready
);
	logic       cart_dl;
	logic       cart_dl_q;
	logic       cart_wr;
	logic [7:0] lo_byte;
	logic [7:0] hi_byte;
	logic [3:0] hex_val;
	hdr_flags_t flags_nxt;

	function automatic hdr_flags_t mark_letter(hdr_flags_t f, logic [7:0] c);
		case (c)
			"J": f.j = 1'b1;
			"U": f.u = 1'b1;
			"E": f.e = 1'b1;
			default: ;
		endcase
		return f;
	endfunction

	assign cart_dl = ioctl.download & ~is_code_index(ioctl.index);
	assign cart_wr = cart_dl & ioctl.wr;
	assign lo_byte = ioctl.data[7:0];
	assign hi_byte = ioctl.data[15:8];
	assign hex_val = lo_byte[3:0] - 4'd7;   // 'A'..'F' to 10..15

	always_comb begin
		flags_nxt = hdr_flags;
		if (ioctl.addr == `HDR_REGION_ADDR) begin
			if (lo_byte >= "0" && lo_byte <= "9") begin
				{flags_nxt.e, flags_nxt.u, flags_nxt.j} = {lo_byte[3], lo_byte[2], lo_byte[0]};
			end else if (lo_byte >= "A" && lo_byte <= "F" && lo_byte != "E") begin
				{flags_nxt.e, flags_nxt.u, flags_nxt.j} = {hex_val[3], hex_val[2], hex_val[0]};
			end
			flags_nxt = mark_letter(flags_nxt, lo_byte);
			flags_nxt = mark_letter(flags_nxt, hi_byte);   // Second letter slot
		end
		if (ioctl.addr == `HDR_REGION2_ADDR)
			flags_nxt = mark_letter(flags_nxt, lo_byte);
	end

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			cart_dl_q <= 1'b0;
			hdr_flags <= '0;
			hdr_ready <= 1'b0;
		end else begin
			cart_dl_q <= cart_dl;
			if (~cart_dl_q & cart_dl) begin
				hdr_flags <= '0;   // New cartridge
			end else if (cart_wr) begin
				hdr_flags <= flags_nxt;
			end
			if (cart_wr && ioctl.addr == `HDR_END_ADDR)
				hdr_ready <= 1'b1;
			if (cart_dl_q & ~cart_dl)
				hdr_ready <= 1'b0;
		end
	end

endmodule

// File: cart_loader/quirk_lookup.sv
//////////////////////////////////////////////////
// Product code capture and per-title quirk table
//////////////////////////////////////////////////
`timescale 1ns/100ps
`include "cart_macros.svh"

module quirk_lookup
	import cart_pkg::*;
(
	input  logic     clk_sys,
	input  logic     RESET,
	input  ioctl_t   ioctl,
	output quirk_t   quirks,
	output gun_cfg_t gun_cfg
);
	logic      cart_dl;
	logic      cart_dl_q;
	logic      cart_wr;
	rom_word_t swapped;
	cart_id_t  cart_id;

	assign cart_dl = ioctl.download & ~is_code_index(ioctl.index);
	assign cart_wr = cart_dl & ioctl.wr;
	assign swapped = {ioctl.data[7:0], ioctl.data[15:8]};   // Even byte sits low

	always_ff @(posedge clk_sys) begin
		if (cart_wr) begin
			case (ioctl.addr)
				`CART_ID_ADDR0: cart_id[63:56] <= ioctl.data[15:8];
				`CART_ID_ADDR1: cart_id[55:40] <= swapped;
				`CART_ID_ADDR2: cart_id[39:24] <= swapped;
				`CART_ID_ADDR3: cart_id[23:8]  <= swapped;
				`CART_ID_ADDR4: cart_id[7:0]   <= ioctl.data[7:0];
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			cart_dl_q <= 1'b0;
			quirks    <= '0;
			gun_cfg   <= '{gun_type: 1'b0, sensor_delay: `GUN_DELAY_DEFAULT};
		end else begin
			cart_dl_q <= cart_dl;
			if (~cart_dl_q & cart_dl)
				quirks <= '0;
			if (cart_wr && ioctl.addr == `CART_ID_ADDR5) begin
				case (cart_id)
					"T-081276", "T-81406 ", "T-081586", "T-81576 ",
					"T-81476 ": quirks.sram <= 1'b1;   // SRAM without header entry
					"MK-1215 ", "G-4060  ", "00001211", "MK-1228 ", "G-5538  ",
					"00004076", "T-12046 ", "T-12053 ",
					"G-4524  ": quirks.eeprom <= 1'b1;   // Serial EEPROM saves
					"T-113016": quirks.noram  <= 1'b1;   // Fake RAM check
					"T-89016 ": quirks.fifo   <= 1'b1;
					"T-574023", "T-574013": quirks.pier <= 1'b1;
					"MK-1229 ", "G-7001  ": quirks.svp  <= 1'b1;   // DSP cartridge
					"T-35036 ", "T-25073 ", "MK-1137-": quirks.fmbusy <= 1'b1;
					default: ;
				endcase

				// Light gun model and sensor timing
				case (cart_id)
					"MK-1533 ": gun_cfg <= '{gun_type: 1'b0, sensor_delay: 8'd100};
					"T-95096-": gun_cfg <= '{gun_type: 1'b1, sensor_delay: 8'd52};
					"T-95136-": gun_cfg <= '{gun_type: 1'b1, sensor_delay: 8'd30};
					"MK-1658 ": gun_cfg <= '{gun_type: 1'b0, sensor_delay: 8'd120};
					"T-081156": gun_cfg <= '{gun_type: 1'b0, sensor_delay: 8'd126};
					default:    gun_cfg <= '{gun_type: 1'b0, sensor_delay: `GUN_DELAY_DEFAULT};
				endcase
			end
		end
	end

endmodule

// File: cart_loader/region_select.sv
//////////////////////////////////////////////////
// Console region choice from header or file ext
//////////////////////////////////////////////////
`timescale 1ns/100ps

module region_select
	import cart_pkg::*;
(
	input  logic         clk_sys,
	input  logic         RESET,
	input  hdr_flags_t   hdr_flags,
	input  logic         hdr_ready,
	input  ioctl_t       ioctl,
	input  region_mode_t region_mode,
	input  region_prio_t region_prio,
	output region_t      region_req,
	output logic         region_set
);
	logic       ready_q;
	logic [2:0] flag_vec;   // Indexed by region_t
	region_t    hdr_pick;

	// First flagged region in priority order, else the order's head
	function automatic region_t pick_region(logic [2:0] flags, region_prio_t prio);
		region_t order [3];
		region_t pick;
		case (prio)
			prio_us_eu_jp: order = '{rgn_us, rgn_eu, rgn_jp};
			prio_eu_us_jp: order = '{rgn_eu, rgn_us, rgn_jp};
			prio_us_jp_eu: order = '{rgn_us, rgn_jp, rgn_eu};
			default:       order = '{rgn_jp, rgn_us, rgn_eu};
		endcase
		pick = order[0];
		for (int i = 2; i >= 0; i--) begin
			if (flags[order[i]])
				pick = order[i];
		end
		return pick;
	endfunction

	assign flag_vec = {hdr_flags.e, hdr_flags.u, hdr_flags.j};
	assign hdr_pick = pick_region(flag_vec, region_prio);

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			ready_q    <= 1'b0;
			region_req <= rgn_jp;
			region_set <= 1'b0;
		end else begin
			ready_q <= hdr_ready;
			if (~ready_q & hdr_ready) begin
				case (region_mode)
					mode_header: begin
						region_req <= hdr_pick;
						region_set <= 1'b1;
					end
					mode_file_ext: begin
						region_req <= region_t'(ioctl.index[7:6]);
						region_set <= |ioctl.index;   // Plain index keeps region
					end
					default: ;   // Auto region off
				endcase
			end
			if (ready_q & ~hdr_ready)
				region_set <= 1'b0;
		end
	end

endmodule

// File: common/cart_macros.svh
//////////////////////////////////////////////////
// Cartridge loader constants
//////////////////////////////////////////////////
`ifndef CART_MACROS_SVH
`define CART_MACROS_SVH

// Header region fields and end of header
`define HDR_REGION_ADDR   25'h1F0
`define HDR_REGION2_ADDR  25'h1F2
`define HDR_END_ADDR      25'h200

// Product code words, the last one triggers the table lookup
`define CART_ID_ADDR0     25'h182
`define CART_ID_ADDR1     25'h184
`define CART_ID_ADDR2     25'h186
`define CART_ID_ADDR3     25'h188
`define CART_ID_ADDR4     25'h18A
`define CART_ID_ADDR5     25'h18C

// Cheat code word offsets within a 16 byte record
`define CHEAT_FLAGS_LO    4'd0
`define CHEAT_FLAGS_HI    4'd2
`define CHEAT_ADDR_LO     4'd4
`define CHEAT_ADDR_HI     4'd6
`define CHEAT_CMP_LO      4'd8
`define CHEAT_CMP_HI      4'd10
`define CHEAT_REPL_LO     4'd12
`define CHEAT_REPL_HI     4'd14

`define GUN_DELAY_DEFAULT 8'd44   // Sensor delay when no title matches

`endif

// File: common/cart_pkg.sv
//////////////////////////////////////////////////
// Cartridge loader types and index decode
//////////////////////////////////////////////////
package cart_pkg;

	typedef logic [24:0] rom_addr_t;   // Byte address of the download
	typedef logic [15:0] rom_word_t;
	typedef logic [7:0]  dl_index_t;   // All ones selects cheat codes
	typedef logic [63:0] cart_id_t;    // Eight ASCII characters
	typedef logic [7:0]  gun_delay_t;

	typedef enum logic [1:0] {rgn_jp, rgn_us, rgn_eu} region_t;
	typedef enum logic [1:0] {mode_header, mode_file_ext, mode_disabled} region_mode_t;
	typedef enum logic [1:0] {
		prio_us_eu_jp,
		prio_eu_us_jp,
		prio_us_jp_eu,
		prio_jp_us_eu
	} region_prio_t;

	// Download stream from the host
	typedef struct packed {
		logic      download;
		logic      wr;
		dl_index_t index;
		rom_addr_t addr;
		rom_word_t data;
	} ioctl_t;

	typedef struct packed {
		logic j;
		logic u;
		logic e;
	} hdr_flags_t;

	typedef struct packed {
		logic sram;
		logic eeprom;
		logic noram;
		logic fifo;
		logic pier;
		logic svp;
		logic fmbusy;
	} quirk_t;

	typedef struct packed {
		logic       gun_type;
		gun_delay_t sensor_delay;
	} gun_cfg_t;

	// Matches the core's cheat word layout, valid on top
	typedef struct packed {
		logic        valid;
		logic [31:0] flags;
		logic [31:0] address;
		logic [31:0] compare;
		logic [31:0] replace;
	} cheat_code_t;

	function automatic logic is_code_index(dl_index_t idx);
		return &idx;
	endfunction

endpackage

// File: logic/cheat_code_loader.sv
//////////////////////////////////////////////////
// Cheat code assembly from the code download
//////////////////////////////////////////////////
`timescale 1ns/100ps
`include "cart_macros.svh"

module cheat_code_loader
	import cart_pkg::*;
(
	input  logic        clk_sys,
	input  logic        RESET,
	input  ioctl_t      ioctl,
	output cheat_code_t cheat
);
	logic        code_wr;
	logic        valid_q;
	logic [31:0] flags_q;
	logic [31:0] addr_q;
	logic [31:0] cmp_q;
	logic [31:0] repl_q;

	assign code_wr = ioctl.download & ioctl.wr & is_code_index(ioctl.index);

	// Last word of a record clocks the code in
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			valid_q <= 1'b0;
		end else begin
			valid_q <= code_wr && (ioctl.addr[3:0] == `CHEAT_REPL_HI);
		end
	end

	always_ff @(posedge clk_sys) begin
		if (code_wr) begin
			case (ioctl.addr[3:0])
				`CHEAT_FLAGS_LO: flags_q[15:0]  <= ioctl.data;
				`CHEAT_FLAGS_HI: flags_q[31:16] <= ioctl.data;
				`CHEAT_ADDR_LO:  addr_q[15:0]   <= ioctl.data;
				`CHEAT_ADDR_HI:  addr_q[31:16]  <= ioctl.data;
				`CHEAT_CMP_LO:   cmp_q[15:0]    <= ioctl.data;
				`CHEAT_CMP_HI:   cmp_q[31:16]   <= ioctl.data;
				`CHEAT_REPL_LO:  repl_q[15:0]   <= ioctl.data;
				`CHEAT_REPL_HI:  repl_q[31:16]  <= ioctl.data;
				default: ;   // Odd offsets carry nothing
			endcase
		end
	end

	assign cheat = '{valid: valid_q, flags: flags_q, address: addr_q,
		compare: cmp_q, replace: repl_q};

endmodule

// File: logic/rom_write_ctrl.sv
//////////////////////////////////////////////////
// ROM write toggle request, loader stall and
// ROM size capture
//////////////////////////////////////////////////
`timescale 1ns/100ps

module rom_write_ctrl
	import cart_pkg::*;
(
	input  logic      clk_sys,
	input  logic      RESET,
	input  ioctl_t    ioctl,
	input  logic      rom_wr_ack,   // Follows rom_wr once written
	output logic      rom_wr,
	output rom_addr_t rom_addr,
	output rom_word_t rom_data,
	output logic      ioctl_wait,
	output rom_addr_t rom_size
);
	logic cart_dl;
	logic cart_dl_q;
	logic cart_wr;

	assign cart_dl = ioctl.download & ~is_code_index(ioctl.index);
	assign cart_wr = cart_dl & ioctl.wr;

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			rom_wr     <= 1'b0;
			ioctl_wait <= 1'b0;
			cart_dl_q  <= 1'b0;
		end else begin
			cart_dl_q <= cart_dl;
			if (cart_wr) begin
				rom_wr     <= ~rom_wr;   // New request
				ioctl_wait <= 1'b1;
			end else if (ioctl_wait && (rom_wr == rom_wr_ack)) begin
				ioctl_wait <= 1'b0;
			end
		end
	end

	// Request word and final size
	always_ff @(posedge clk_sys) begin
		if (cart_wr) begin
			rom_addr <= ioctl.addr;
			rom_data <= {ioctl.data[7:0], ioctl.data[15:8]};
		end
		if (cart_dl_q & ~cart_dl) begin
			rom_size <= ioctl.addr;   // Last address of the download
		end
	end

endmodule

// File: sources.f
+incdir+common
common/cart_pkg.sv
logic/rom_write_ctrl.sv
logic/cheat_code_loader.sv
cart_loader/header_region.sv
cart_loader/region_select.sv
cart_loader/quirk_lookup.sv
cart_loader/cart_loader_top.sv
test/cart_loader_checker.sv
test/cart_loader_tb.sv

// File: test/cart_loader_checker.sv
//////////////////////////////////////////////////
// Handshake and pulse rules of the cartridge loader
//////////////////////////////////////////////////
`timescale 1ns/100ps

module cart_loader_checker
	import cart_pkg::*;
(
	input logic        clk_sys,
	input logic        RESET,
	input ioctl_t      ioctl,
	input logic        ioctl_wait,
	input logic        hdr_ready,
	input logic        region_set,
	input cheat_code_t cheat
);
	logic cart_wr;
	int   fail_count = 0;   // Failed assertions so far

	assign cart_wr = ioctl.download & ioctl.wr & ~is_code_index(ioctl.index);

	// Stall starts only on a ROM word
	wait_after_write: assert property (@(posedge clk_sys) disable iff (RESET)
		$rose(ioctl_wait) |-> $past(cart_wr))
		else begin
			$error("ioctl_wait rose without a cartridge write");
			fail_count++;
		end

	valid_one_cycle: assert property (@(posedge clk_sys) disable iff (RESET)
		cheat.valid |=> !cheat.valid)
		else begin
			$error("cheat valid held longer than one cycle");
			fail_count++;
		end

	set_needs_ready: assert property (@(posedge clk_sys) disable iff (RESET)
		$rose(region_set) |-> hdr_ready)
		else begin
			$error("region_set rose while hdr_ready was low");
			fail_count++;
		end

endmodule

bind cart_loader_top cart_loader_checker chk0 (
	.clk_sys    (clk_sys),
	.RESET      (RESET),
	.ioctl      (ioctl),
	.ioctl_wait (ioctl_wait),
	.hdr_ready  (hdr_ready),
	.region_set (region_set),
	.cheat      (cheat)
);

// File: test/cart_loader_tb.sv
//////////////////////////////////////////////////
// Cartridge loader testbench driving random
// downloads against a reference model
//////////////////////////////////////////////////
`timescale 1ns/100ps
`include "cart_macros.svh"

module cart_loader_tb
	import cart_pkg::*;
();
	logic         clk_sys = 1'b0;
	logic         RESET;
	ioctl_t       ioctl;
	region_mode_t region_mode;
	region_prio_t region_prio;
	logic         rom_wr_ack;
	logic         rom_wr;
	rom_addr_t    rom_addr;
	rom_word_t    rom_data;
	logic         ioctl_wait;
	rom_addr_t    rom_size;
	region_t      region_req;
	logic         region_set;
	quirk_t       quirks;
	gun_cfg_t     gun_cfg;
	cheat_code_t  cheat;

	logic       exp_rom_wr;      // Expected request toggle
	cart_id_t   code_tab [12];
	logic [6:0] quirk_tab [12];  // Sram on top and fmbusy at bit 0
	logic [8:0] gun_tab [12];

	cart_loader_top dut0 (.*);

	always #4 clk_sys = ~clk_sys;

	// Memory model acks each new request after 0 to 5 cycles
	always begin
		@(posedge clk_sys);
		#1;
		if (!RESET && rom_wr !== rom_wr_ack) begin
			repeat ($urandom_range(0, 5)) begin
				@(posedge clk_sys);
				#1;
			end
			rom_wr_ack = rom_wr;
		end
	end

	// A failed bound assertion ends the run
	always @(posedge clk_sys) begin
		if (dut0.chk0.fail_count != 0)
			abort_run();
	end

	//////////////////////////////////////////////////
	// Checks and waits

	task automatic abort_run();
		$display("Errors found");
		$fatal(1);
	endtask

	task automatic check_value(string name, logic [63:0] got, logic [63:0] exp);
		if (got !== exp) begin
			$display("Error %s: got %h expected %h", name, got, exp);
			abort_run();
		end
	endtask

	task automatic report_timeout(string what);
		$display("Timed out waiting for %s", what);
		abort_run();
	endtask

	task automatic next_cycle();
		@(posedge clk_sys);
		#1;
	endtask

	task automatic wait_header_ready();
		int n;
		n = 0;
		while (!dut0.hdr_ready) begin
			if (n == 10)
				report_timeout("hdr_ready after the header end word");
			next_cycle();
			n++;
		end
	endtask

	// One ROM word and a hold off until the memory takes it
	task automatic cart_write(rom_addr_t addr, rom_word_t data);
		int n;
		ioctl.wr   = 1'b1;
		ioctl.addr = addr;
		ioctl.data = data;
		next_cycle();
		ioctl.wr   = 1'b0;
		exp_rom_wr = ~exp_rom_wr;
		check_value("rom_wr", rom_wr, exp_rom_wr);
		check_value("rom_addr", rom_addr, addr);
		check_value("rom_data", rom_data, {data[7:0], data[15:8]});
		check_value("ioctl_wait", ioctl_wait, 1'b1);
		n = 0;
		while (ioctl_wait) begin
			if (n == 20)
				report_timeout("ioctl_wait to clear after the ROM ack");
			next_cycle();
			n++;
		end
		check_value("rom_wr_ack", rom_wr_ack, rom_wr);
	endtask

	task automatic code_write(rom_addr_t addr, rom_word_t data);
		ioctl.wr   = 1'b1;
		ioctl.addr = addr;
		ioctl.data = data;
		next_cycle();
		ioctl.wr   = 1'b0;
		check_value("ioctl_wait", ioctl_wait, 1'b0);
		check_value("cheat.valid", cheat.valid, addr[3:0] == 4'd14);
	endtask

	task automatic start_download(dl_index_t idx);
		ioctl.download = 1'b1;
		ioctl.index    = idx;
		next_cycle();
	endtask

	//////////////////////////////////////////////////
	// Reference model

	function automatic logic [2:0] letter_flag(logic [7:0] c);   // {j, u, e}
		case (c)
			"J": return 3'b100;
			"U": return 3'b010;
			"E": return 3'b001;
			default: return 3'b000;
		endcase
	endfunction

	function automatic logic [2:0] header_flags(logic [7:0] lo, logic [7:0] hi, logic [7:0] lo2);
		logic [2:0] f;
		logic [7:0] v;
		f = 3'b000;
		if (letter_flag(lo) == 3'b000) begin
			if (lo >= "0" && lo <= "9") begin
				v = lo - "0";
				f = {v[0], v[2], v[3]};
			end else if (lo >= "A" && lo <= "F") begin
				v = lo - "A" + 8'd10;   // Hex digit value
				f = {v[0], v[2], v[3]};
			end
		end
		return f | letter_flag(lo) | letter_flag(hi) | letter_flag(lo2);
	endfunction

	function automatic region_t expected_region(logic [2:0] f, region_prio_t prio);
		logic [5:0] order;   // First choice in the top bits
		logic [2:0] want;
		region_t    r;
		region_t    c;
		logic       found;
		case (prio)
			prio_us_eu_jp: order = {rgn_us, rgn_eu, rgn_jp};
			prio_eu_us_jp: order = {rgn_eu, rgn_us, rgn_jp};
			prio_us_jp_eu: order = {rgn_us, rgn_jp, rgn_eu};
			default:       order = {rgn_jp, rgn_us, rgn_eu};
		endcase
		r = region_t'(order[5:4]);
		found = 1'b0;
		for (int k = 0; k < 3; k++) begin
			c = region_t'(order[5 - 2 * k -: 2]);
			want = (c == rgn_jp) ? 3'b100 : (c == rgn_us) ? 3'b010 : 3'b001;
			if (!found && (f & want) != 3'b000) begin
				r = c;
				found = 1'b1;
			end
		end
		return r;
	endfunction

	function automatic logic [7:0] region_char();
		case ($urandom_range(0, 4))
			0: return ($urandom_range(0, 2) == 0) ? "J" : ($urandom_range(0, 1) ? "U" : "E");
			1: return 8'("0" + $urandom_range(0, 9));
			2: return 8'("A" + $urandom_range(0, 5));
			3: return " ";
			default: return 8'($urandom_range(8'h20, 8'h7E));
		endcase
	endfunction

	//////////////////////////////////////////////////
	// Download sequences

	task automatic run_cart_download(int i);
		cart_id_t   code;
		dl_index_t  idx;
		logic [7:0] lo;
		logic [7:0] hi;
		logic [7:0] lo2;
		logic [7:0] img [16];   // Header bytes from 0x180
		rom_addr_t  addr;
		logic [6:0] exp_quirks;
		logic [8:0] exp_gun;
		code = "X-000000";
		if (i < 12) begin
			code = code_tab[i];
		end else begin
			for (int c = 2; c < 8; c++)
				code[63 - 8 * c -: 8] = 8'($urandom_range(65, 90));
		end
		exp_quirks = '0;
		exp_gun    = {1'b0, `GUN_DELAY_DEFAULT};
		for (int k = 0; k < 12; k++) begin
			if (code_tab[k] == code) begin
				exp_quirks = quirk_tab[k];
				exp_gun    = gun_tab[k];
			end
		end
		case (i % 8)
			6: region_mode = mode_file_ext;
			7: region_mode = mode_disabled;
			default: region_mode = mode_header;
		endcase
		region_prio = region_prio_t'(i % 4);
		idx = (i == 6) ? 8'h00 : 8'($urandom_range(0, 254));
		lo  = region_char();
		hi  = region_char();
		lo2 = region_char();

		start_download(idx);
		check_value("quirks", quirks, 7'd0);
		for (int k = 0; k < 4; k++)
			cart_write(25'(2 * k), 16'($urandom));

		// Product code sits at 0x183 with the even byte in the low half
		for (int k = 0; k < 16; k++)
			img[k] = " ";
		for (int c = 0; c < 8; c++)
			img[3 + c] = code[63 - 8 * c -: 8];
		for (int k = 0; k < 6; k++)
			cart_write(`CART_ID_ADDR0 + 25'(2 * k), {img[2 * k + 3], img[2 * k + 2]});
		check_value("quirks", quirks, exp_quirks);
		check_value("gun_cfg", gun_cfg, exp_gun);

		cart_write(`HDR_REGION_ADDR, {hi, lo});
		cart_write(`HDR_REGION2_ADDR, {8'($urandom), lo2});
		cart_write(`HDR_END_ADDR, 16'($urandom));
		wait_header_ready();
		next_cycle();
		case (region_mode)
			mode_header: begin
				check_value("region_set", region_set, 1'b1);
				check_value("region_req", region_req,
					expected_region(header_flags(lo, hi, lo2), region_prio));
			end
			mode_file_ext: begin
				check_value("region_set", region_set, idx != 8'h00);
				check_value("region_req", region_req, idx[7:6]);
			end
			default: check_value("region_set", region_set, 1'b0);
		endcase

		addr = `HDR_END_ADDR;
		repeat ($urandom_range(0, 7)) begin
			addr = addr + 25'd2;
			cart_write(addr, 16'($urandom));
		end
		ioctl.download = 1'b0;
		next_cycle();
		check_value("rom_size", rom_size, addr);
		check_value("hdr_ready", dut0.hdr_ready, 1'b0);
		next_cycle();
		check_value("region_set", region_set, 1'b0);
	endtask

	task automatic run_cheat_download();
		rom_word_t w [8];
		rom_addr_t base;
		start_download(8'hFF);
		repeat ($urandom_range(1, 3)) begin
			base = 25'($urandom_range(0, 4095)) << 4;
			for (int k = 0; k < 8; k++) begin
				w[k] = 16'($urandom);
				code_write(base + 25'(2 * k), w[k]);
			end
			check_value("cheat.flags", cheat.flags, {w[1], w[0]});
			check_value("cheat.address", cheat.address, {w[3], w[2]});
			check_value("cheat.compare", cheat.compare, {w[5], w[4]});
			check_value("cheat.replace", cheat.replace, {w[7], w[6]});
		end
		ioctl.download = 1'b0;
		next_cycle();
		check_value("cheat.valid", cheat.valid, 1'b0);
	endtask

	initial begin
		RESET       = 1'b1;
		ioctl       = '0;
		region_mode = mode_header;
		region_prio = prio_us_eu_jp;
		rom_wr_ack  = 1'b0;
		exp_rom_wr  = 1'b0;
		void'($urandom(92));

		// Titles with a known quirk or light gun
		code_tab = '{"T-081276", "MK-1215 ", "T-113016", "T-89016 ", "T-574023", "MK-1229 ",
			"T-35036 ", "MK-1533 ", "T-95096-", "T-95136-", "MK-1658 ", "T-081156"};
		quirk_tab = '{7'b1000000, 7'b0100000, 7'b0010000, 7'b0001000, 7'b0000100,
			7'b0000010, 7'b0000001, 7'd0, 7'd0, 7'd0, 7'd0, 7'd0};
		gun_tab = '{9'h02C, 9'h02C, 9'h02C, 9'h02C, 9'h02C, 9'h02C, 9'h02C,
			{1'b0, 8'd100}, {1'b1, 8'd52}, {1'b1, 8'd30}, {1'b0, 8'd120}, {1'b0, 8'd126}};

		repeat (2) @(posedge clk_sys);
		#1;
		RESET = 1'b0;
		check_value("rom_wr", rom_wr, 1'b0);
		check_value("ioctl_wait", ioctl_wait, 1'b0);
		check_value("region_set", region_set, 1'b0);
		check_value("cheat.valid", cheat.valid, 1'b0);
		check_value("quirks", quirks, 7'd0);
		check_value("gun_cfg", gun_cfg, {1'b0, `GUN_DELAY_DEFAULT});

		for (int i = 0; i < 24; i++) begin
			run_cart_download(i);
			if (i % 4 == 3)
				run_cheat_download();
		end

		if (dut0.chk0.fail_count == 0) begin
			$display("No errors");
			$finish;
		end else begin
			abort_run();
		end
	end

endmodule
